// ==== rtl/icache_pkg.sv ====
package icache_pkg;

	// cache geometry
	localparam int NUM_SETS       = 64;
	localparam int NUM_WAYS       = 2;
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_BITS      = 256;
	localparam int TAG_BITS       = 53;
	localparam int INDEX_BITS     = 6;

	// 64-bit fetch address as seen by the cache
	typedef struct packed {
		logic [TAG_BITS-1:0]   tag;
		logic [INDEX_BITS-1:0] index;
		logic [1:0]            word;   // word within the 32-byte line
		logic [2:0]            offset; // byte within the word, ignored
	} fetch_addr_t;

	// controller states
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		REFILL,
		RESPOND
	} ctrl_state_t;

endpackage

// ==== rtl/mem_bus_pkg.sv ====
package mem_bus_pkg;

	// depth of the memory request queue, one credit per slot
	localparam int REQ_CREDITS = 2;
	localparam int CREDIT_BITS = $clog2(REQ_CREDITS + 1);

	// line refill request
	typedef struct packed {
		logic [58:0] line_addr; // fetch address without the 5 offset bits
	} mem_req_t;

	// one refill beat, always in order
	typedef struct packed {
		logic [63:0] data;
		logic        last;
	} mem_beat_t;

endpackage

// ==== rtl/icache_tag_array.sv ====
module icache_tag_array
	import icache_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  flush,
	input  logic                  rd_en,
	input  logic [INDEX_BITS-1:0] rd_index,
	input  logic [TAG_BITS-1:0]   cmp_tag,
	output logic                  hit,
	output logic                  hit_way,
	output logic                  victim_way,
	input  logic                  fill_en,
	input  logic                  fill_way,
	input  logic [INDEX_BITS-1:0] fill_index,
	input  logic [TAG_BITS-1:0]   fill_tag
);

	logic [TAG_BITS-1:0]               tag_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
	logic [NUM_SETS-1:0]               lru_q; // holds the least recently used way

	logic [TAG_BITS-1:0]   rd_tag [NUM_WAYS];
	logic [NUM_WAYS-1:0]   rd_valid;
	logic                  rd_lru;
	logic [INDEX_BITS-1:0] rd_index_q;
	logic                  rd_pend; // registered set is fresh this cycle
	logic [NUM_WAYS-1:0]   way_match;

	// set read and tag writes
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_index_q <= rd_index;
			rd_lru     <= lru_q[rd_index];
			for (int w = 0; w < NUM_WAYS; w++) begin
				rd_tag[w]   <= tag_mem[w][rd_index];
				rd_valid[w] <= valid_q[w][rd_index];
			end
		end
		if (fill_en)
			tag_mem[fill_way][fill_index] <= fill_tag;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_pend <= 1'b0;
			valid_q <= '0;
			lru_q   <= '0;
		end else begin
			rd_pend <= rd_en;
			if (flush) begin
				valid_q <= '0;
				lru_q   <= '0;
			end else begin
				if (hit)
					lru_q[rd_index_q] <= ~hit_way;
				if (fill_en) begin
					valid_q[fill_way][fill_index] <= 1'b1;
					lru_q[fill_index]             <= ~fill_way; // filled way is most recent
				end
			end
		end
	end

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++)
			way_match[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
	end

	assign hit     = rd_pend && (|way_match);
	assign hit_way = way_match[1];

	// first invalid way, else lru
	assign victim_way = !rd_valid[0] ? 1'b0 : (!rd_valid[1] ? 1'b1 : rd_lru);

endmodule

// ==== rtl/icache_data_array.sv ====
module icache_data_array
	import icache_pkg::*;
(
	input  logic                  clk,
	input  logic                  rd_en,
	input  logic [INDEX_BITS-1:0] rd_index,
	input  logic                  rd_way,
	input  logic [1:0]            rd_word,
	output logic [63:0]           rd_data,
	input  logic                  wr_en,
	input  logic                  wr_way,
	input  logic [INDEX_BITS-1:0] wr_index,
	input  logic [1:0]            wr_word,
	input  logic [63:0]           wr_data
);

	logic [LINE_BITS-1:0] line_mem [NUM_WAYS][NUM_SETS];
	logic [LINE_BITS-1:0] rd_line [NUM_WAYS]; // both ways of the read set

	// one beat per write
	always_ff @(posedge clk) begin
		if (wr_en)
			line_mem[wr_way][wr_index][wr_word*64 +: 64] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			for (int w = 0; w < NUM_WAYS; w++)
				rd_line[w] <= line_mem[w][rd_index];
		end
	end

	// way and word picked after the tag compare
	assign rd_data = rd_line[rd_way][rd_word*64 +: 64];

endmodule

// ==== rtl/icache_refill.sv ====
module icache_refill
	import icache_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  fetch_addr_t           line_addr,
	input  logic                  way,
	output logic                  mem_req_valid,
	output mem_req_t              mem_req,
	input  logic                  mem_credit,
	input  logic                  mem_beat_valid,
	input  mem_beat_t             mem_beat,
	output logic                  wr_en,
	output logic                  wr_way,
	output logic [INDEX_BITS-1:0] wr_index,
	output logic [1:0]            wr_word,
	output logic [63:0]           wr_data,
	output logic                  fill_en,
	output logic                  fill_way,
	output logic [INDEX_BITS-1:0] fill_index,
	output logic [TAG_BITS-1:0]   fill_tag,
	output logic                  done
);

	logic [CREDIT_BITS-1:0]            credits;
	logic                              pending; // request not yet sent
	logic                              busy;    // line in flight
	logic [$clog2(WORDS_PER_LINE)-1:0] beat_cnt;
	fetch_addr_t                       line_q;
	logic                              way_q;

	// request leaves as soon as a credit is held
	assign mem_req_valid     = pending && (credits != '0);
	assign mem_req.line_addr = {line_q.tag, line_q.index};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= CREDIT_BITS'(REQ_CREDITS);
		end else begin
			case ({mem_credit, mem_req_valid})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits; // none or both
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending  <= 1'b0;
			busy     <= 1'b0;
			beat_cnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= fill_en;
			if (start) begin
				pending  <= 1'b1;
				busy     <= 1'b1;
				beat_cnt <= '0;
			end else begin
				if (mem_req_valid)
					pending <= 1'b0;
				if (wr_en)
					beat_cnt <= beat_cnt + 1'b1;
				if (fill_en)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			line_q <= line_addr;
			way_q  <= way;
		end
	end

	// beats go straight into the data array
	assign wr_en    = busy && mem_beat_valid;
	assign wr_way   = way_q;
	assign wr_index = line_q.index;
	assign wr_word  = beat_cnt;
	assign wr_data  = mem_beat.data;

	assign fill_en    = wr_en && mem_beat.last; // tag and valid with the last word
	assign fill_way   = way_q;
	assign fill_index = line_q.index;
	assign fill_tag   = line_q.tag;

endmodule

// ==== rtl/icache_ctrl.sv ====
module icache_ctrl
	import icache_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush,
	input  logic        req_valid,
	input  fetch_addr_t req_addr,
	output logic        req_ready,
	output logic        resp_valid,
	output logic [63:0] resp_data,
	input  logic        hit,
	output logic        rd_en,
	output fetch_addr_t lookup_addr,
	output logic        refill_start,
	input  logic        refill_done,
	input  logic [63:0] rd_data
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	fetch_addr_t addr_q; // accepted fetch address
	logic        up_q;   // low until the first edge out of reset
	logic        accept;

	// no new fetch while a flush is pending
	assign req_ready = up_q && (state_q == IDLE) && !flush;
	assign accept    = req_valid && req_ready;

	// arrays read at acceptance and again once the line is in
	assign rd_en        = accept || ((state_q == REFILL) && refill_done);
	assign lookup_addr  = (state_q == IDLE) ? req_addr : addr_q;
	assign refill_start = (state_q == LOOKUP) && !hit;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (accept)
					state_d = LOOKUP;
			end
			LOOKUP:  state_d = hit ? RESPOND : REFILL;
			REFILL: begin
				if (refill_done)
					state_d = LOOKUP;
			end
			RESPOND: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q    <= IDLE;
			up_q       <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			state_q    <= state_d;
			up_q       <= 1'b1;
			resp_valid <= (state_q == RESPOND); // single pulse
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			addr_q <= req_addr;
		if ((state_q == LOOKUP) && hit)
			resp_data <= rd_data;
	end

endmodule

// ==== rtl/icache_top.sv ====
module icache_top
	import icache_pkg::*;
	import mem_bus_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush,
	input  logic        req_valid,
	input  fetch_addr_t req_addr,
	output logic        req_ready,
	output logic        resp_valid,
	output logic [63:0] resp_data,
	output logic        mem_req_valid,
	output mem_req_t    mem_req,
	input  logic        mem_credit,
	input  logic        mem_beat_valid,
	input  mem_beat_t   mem_beat
);

	fetch_addr_t           lookup_addr;
	logic                  rd_en;
	logic                  hit;
	logic                  hit_way;
	logic                  victim_way;
	logic [63:0]           rd_data;
	logic                  refill_start;
	logic                  refill_done;
	logic                  wr_en;
	logic                  wr_way;
	logic [INDEX_BITS-1:0] wr_index;
	logic [1:0]            wr_word;
	logic [63:0]           wr_data;
	logic                  fill_en;
	logic                  fill_way;
	logic [INDEX_BITS-1:0] fill_index;
	logic [TAG_BITS-1:0]   fill_tag;

	icache_ctrl i_icache_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush        (flush),
		.req_valid    (req_valid),
		.req_addr     (req_addr),
		.req_ready    (req_ready),
		.resp_valid   (resp_valid),
		.resp_data    (resp_data),
		.hit          (hit),
		.rd_en        (rd_en),
		.lookup_addr  (lookup_addr),
		.refill_start (refill_start),
		.refill_done  (refill_done),
		.rd_data      (rd_data)
	);

	icache_tag_array i_icache_tag_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.rd_en      (rd_en),
		.rd_index   (lookup_addr.index),
		.cmp_tag    (lookup_addr.tag),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way),
		.fill_en    (fill_en),
		.fill_way   (fill_way),
		.fill_index (fill_index),
		.fill_tag   (fill_tag)
	);

	icache_data_array i_icache_data_array (
		.clk      (clk),
		.rd_en    (rd_en),
		.rd_index (lookup_addr.index),
		.rd_way   (hit_way),
		.rd_word  (lookup_addr.word),
		.rd_data  (rd_data),
		.wr_en    (wr_en),
		.wr_way   (wr_way),
		.wr_index (wr_index),
		.wr_word  (wr_word),
		.wr_data  (wr_data)
	);

	// victim chosen by the tag array at the miss
	icache_refill i_icache_refill (
		.clk            (clk),
		.rst_n          (rst_n),
		.start          (refill_start),
		.line_addr      (lookup_addr),
		.way            (victim_way),
		.mem_req_valid  (mem_req_valid),
		.mem_req        (mem_req),
		.mem_credit     (mem_credit),
		.mem_beat_valid (mem_beat_valid),
		.mem_beat       (mem_beat),
		.wr_en          (wr_en),
		.wr_way         (wr_way),
		.wr_index       (wr_index),
		.wr_word        (wr_word),
		.wr_data        (wr_data),
		.fill_en        (fill_en),
		.fill_way       (fill_way),
		.fill_index     (fill_index),
		.fill_tag       (fill_tag),
		.done           (refill_done)
	);

endmodule

// ==== tests/icache_checker.sv ====
module icache_checker
	import mem_bus_pkg::*;
(
	input logic                   clk,
	input logic                   rst_n,
	input logic                   mem_req_valid,
	input logic                   mem_credit,
	input logic                   mem_beat_valid,
	input logic                   busy,
	input logic [CREDIT_BITS-1:0] credits
);

	timeunit 1ns;
	timeprecision 1ps;

	int credits_seen; // credits counted from the bus pulses alone

	always_ff @(posedge clk) begin
		if (!rst_n)
			credits_seen <= REQ_CREDITS;
		else
			credits_seen <= credits_seen + int'(mem_credit) - int'(mem_req_valid);
	end

	// one credit must be held for each request
	req_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid |-> credits_seen > 0)
		else $error("memory request issued with no credits");

	credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= REQ_CREDITS)
		else $error("credit count above the request queue depth");

	req_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid |=> !mem_req_valid)
		else $error("memory request held for more than one cycle");

	// beats only belong to a line in flight
	beat_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
		mem_beat_valid |-> busy)
		else $error("refill beat arrived with no refill in progress");

endmodule

// ==== tests/tb_icache.sv ====
module tb_icache
	import icache_pkg::*;
	import mem_bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [63:0] DATA_XOR = 64'hA5A5_0000_5A5A_FFFF;
	localparam int NUM_TESTS = 5;
	localparam int TEST_BUDGET_NS = 5000;

	logic        clk;
	logic        rst_n;
	logic        flush;
	logic        req_valid;
	fetch_addr_t req_addr;
	logic        req_ready;
	logic        resp_valid;
	logic [63:0] resp_data;
	logic        mem_req_valid;
	mem_req_t    mem_req;
	logic        mem_credit;
	logic        mem_beat_valid;
	mem_beat_t   mem_beat;

	integer      seed;
	int          errors = 0;
	int          pass_count = 0;
	int          fail_count = 0;
	int          last_latency;

	// memory model state
	logic [58:0] line_fifo [$];
	logic [58:0] last_line;
	int          req_count = 0;
	int          owed = 0;         // credits held by the memory
	int          credit_timer = 0;
	int          beat_wait = 0;
	int          beat_idx = 0;
	bit          credit_en;

	// reference tags and lru bits
	logic [52:0] ref_tag [64][2];
	bit          ref_valid [64][2];
	bit          ref_lru [64]; // least recently used way

	icache_top i_icache_top (.*);

	bind icache_refill icache_checker i_icache_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_req_valid  (mem_req_valid),
		.mem_credit     (mem_credit),
		.mem_beat_valid (mem_beat_valid),
		.busy           (busy),
		.credits        (credits)
	);

	always #10 clk = ~clk;

	function automatic logic [63:0] word_data(input logic [63:0] addr);
		return {addr[63:3], 3'b000} ^ DATA_XOR;
	endfunction

	// returns 1 when the access misses and updates the reference
	function automatic int ref_access(input logic [63:0] addr);
		int          idx;
		logic [52:0] tag;
		int          victim;
		idx = int'(addr[10:5]);
		tag = addr[63:11];
		for (int w = 0; w < 2; w++) begin
			if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
				ref_lru[idx] = (w == 0);
				return 0;
			end
		end
		victim = !ref_valid[idx][0] ? 0 : (!ref_valid[idx][1] ? 1 : int'(ref_lru[idx]));
		ref_tag[idx][victim]   = tag;
		ref_valid[idx][victim] = 1'b1;
		ref_lru[idx]           = (victim == 0);
		return 1;
	endfunction

	always @(negedge clk) begin
		mem_credit     = 1'b0;
		mem_beat_valid = 1'b0;
		if (rst_n) begin
			if (mem_req_valid) begin
				req_count++;
				last_line = mem_req.line_addr;
				line_fifo.push_back(mem_req.line_addr);
				if (owed == 0)
					credit_timer = 2 + ($random(seed) & 3);
				owed++;
				if (line_fifo.size() == 1)
					beat_wait = 3;
			end
			// credits come back one at a time a few cycles apart
			if (credit_en && owed > 0) begin
				if (credit_timer == 0) begin
					mem_credit   = 1'b1;
					owed--;
					credit_timer = 2 + ($random(seed) & 3);
				end else begin
					credit_timer--;
				end
			end
			// four in-order beats per line
			if (line_fifo.size() > 0) begin
				if (beat_wait > 0) begin
					beat_wait--;
				end else begin
					mem_beat_valid = 1'b1;
					mem_beat.data  = word_data({line_fifo[0], 5'b00000} + 64'(beat_idx * 8));
					mem_beat.last  = (beat_idx == 3);
					if (beat_idx == 3) begin
						void'(line_fifo.pop_front());
						beat_idx  = 0;
						beat_wait = 3;
					end else begin
						beat_idx++;
					end
				end
			end
		end
	end

	task automatic report_error(input string msg);
		$display("error at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic record_result(input string name, input int e0);
		if (errors == e0) begin
			pass_count++;
			$display("%s: passed", name);
		end else begin
			fail_count++;
			$display("%s: failed with %0d errors", name, errors - e0);
		end
	endtask

	// latency counts cycles from acceptance to resp_valid
	task automatic fetch(input logic [63:0] addr, output logic [63:0] data, output int lat);
		@(negedge clk);
		req_valid = 1'b1;
		req_addr  = addr;
		while (!req_ready)
			@(negedge clk);
		@(negedge clk); // accepted at the edge in between
		req_valid = 1'b0;
		lat = 0;
		while (!resp_valid) begin
			@(negedge clk);
			lat++;
		end
		data = resp_data;
	endtask

	task automatic fetch_check(input logic [63:0] addr, input int exp_reqs);
		int          reqs0;
		logic [63:0] data;
		reqs0 = req_count;
		fetch(addr, data, last_latency);
		if (data !== word_data(addr))
			report_error($sformatf("data %h for address %h, expected %h",
				data, addr, word_data(addr)));
		if (req_count - reqs0 != exp_reqs)
			report_error($sformatf("%0d memory requests for address %h, expected %0d",
				req_count - reqs0, addr, exp_reqs));
	endtask

	task automatic pulse_flush();
		@(negedge clk);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
	endtask

	task automatic cold_miss_then_hit();
		int e0;
		e0 = errors;
		fetch_check(64'h0000_0000_0040_0040, 1);
		if (last_line !== 59'(64'h0000_0000_0040_0040 >> 5))
			report_error($sformatf("request for line %h", last_line));
		fetch_check(64'h0000_0000_0040_0048, 0);
		if (last_latency != 2)
			report_error($sformatf("hit took %0d cycles, expected 2", last_latency));
		record_result("cold miss then hit", e0);
	endtask

	task automatic lru_replacement();
		int e0;
		e0 = errors;
		fetch_check(64'h0000_1000_0000_00A0, 1);
		fetch_check(64'h0000_2000_0000_00A8, 1);
		fetch_check(64'h0000_1000_0000_00B8, 0); // first tag becomes most recent
		fetch_check(64'h0000_3000_0000_00B0, 1); // evicts the second tag
		fetch_check(64'h0000_1000_0000_00A0, 0);
		fetch_check(64'h0000_2000_0000_00A8, 1);
		record_result("lru replacement", e0);
	endtask

	task automatic flush_invalidates();
		int e0;
		e0 = errors;
		fetch_check(64'h0000_0000_0040_0040, 0);
		pulse_flush();
		fetch_check(64'h0000_0000_0040_0040, 1);
		record_result("flush", e0);
	endtask

	task automatic credit_stall();
		int e0;
		int base;
		e0 = errors;
		while (owed != 0)
			@(negedge clk);
		credit_en = 1'b0;
		fetch_check(64'h0000_0000_0000_1000, 1);
		fetch_check(64'h0000_0000_0000_2000, 1);
		base = req_count;
		fork
			fetch_check(64'h0000_0000_0000_3008, 1);
			begin
				repeat (20) @(negedge clk);
				if (req_count != base)
					report_error("memory request sent while no credits were held");
				credit_en = 1'b1;
			end
		join
		record_result("credit stall", e0);
	endtask

	task automatic random_fetches();
		int          e0;
		int          idx;
		int          word;
		logic [52:0] tag;
		logic [63:0] addr;
		e0 = errors;
		pulse_flush();
		foreach (ref_valid[s, w])
			ref_valid[s][w] = 1'b0;
		for (int i = 0; i < 40; i++) begin
			idx  = 8 + ($random(seed) & 3);
			tag  = 53'h40 + 53'({$random(seed)} % 3);
			word = $random(seed) & 3;
			addr = {tag, 6'(idx), 2'(word), 3'b000};
			fetch_check(addr, ref_access(addr));
		end
		record_result("random fetches", e0);
	endtask

	initial begin
		clk            = 1'b0;
		rst_n          = 1'b0;
		flush          = 1'b0;
		req_valid      = 1'b0;
		req_addr       = '0;
		mem_credit     = 1'b0;
		mem_beat_valid = 1'b0;
		mem_beat       = '0;
		seed           = 71;
		credit_en      = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		cold_miss_then_hit();
		lru_replacement();
		flush_invalidates();
		credit_stall();
		random_fetches();

		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// budget of a few microseconds per test
	initial begin
		#(NUM_TESTS * TEST_BUDGET_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
rtl/icache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_refill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tests/icache_checker.sv
tests/tb_icache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_icache -f verilog.f -o sim_icache
./obj_dir/sim_icache | tee sim.log

if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
